//--- design/link_test_pkg.sv
`default_nettype none

package link_test_pkg;

        // coded block layout
        localparam int NB_CODED_BLOCK = 66;
        localparam int NB_SH          = 2;
        localparam int NB_PAYLOAD     = NB_CODED_BLOCK - NB_SH;
        localparam logic [NB_SH-1:0] SH_DATA = 2'b01;       // data block sync header

        // injector config and counter widths
        localparam int NB_BURST_CNT  = 10;
        localparam int NB_PERIOD_CNT = 10;
        localparam int NB_REPEAT_CNT = 4;

        localparam int NB_BLOCK_CNT = 16;                   // block count and result counters
        localparam int NB_BIT_ERR   = 24;                   // flipped bit total
        localparam int NB_GAP       = 4;                    // idle cycles between blocks
        localparam int NB_PRBS      = 31;                   // lfsr length, x^31 + x^28 + 1

        typedef struct packed {
                logic [NB_SH-1:0]      sh;
                logic [NB_PAYLOAD-1:0] payload;
        } coded_block_t;

        typedef struct packed {
                logic [NB_PAYLOAD-1:0]    error_mask;       // 1 = flip this payload bit
                logic [NB_BURST_CNT-1:0]  error_burst;      // corrupted blocks per period
                logic [NB_PERIOD_CNT-1:0] error_period;     // blocks per period, 0 = off
                logic [NB_REPEAT_CNT-1:0] error_repeat;     // number of errored periods
        } err_cfg_t;

        typedef struct packed {
                err_cfg_t                err_cfg;
                logic [NB_BLOCK_CNT-1:0] num_blocks;
                logic [NB_GAP-1:0]       gap;
        } test_cfg_t;

        typedef struct packed {
                logic [NB_BLOCK_CNT-1:0] blocks_seen;
                logic [NB_BLOCK_CNT-1:0] errored_blocks;
                logic [NB_BLOCK_CNT-1:0] header_errors;
                logic [NB_BIT_ERR-1:0]   bit_errors;
        } test_report_t;

        typedef enum logic [2:0] {IDLE, LOAD, RUN, DRAIN, DONE} ctrl_state_t;

        // 64 prbs bits from a given state, oldest bit lands in the msb
        // the low 31 bits of the result are also the next lfsr state
        function automatic logic [NB_PAYLOAD-1:0] prbs31_block(input logic [NB_PRBS-1:0] state);
                logic [NB_PRBS-1:0]    s;
                logic [NB_PAYLOAD-1:0] data;
                logic                  fb;
                s    = state;
                data = '0;
                for (int i = 0; i < NB_PAYLOAD; i++)
                begin
                        fb   = s[30] ^ s[27];               // taps 31 and 28
                        s    = {s[NB_PRBS-2:0], fb};
                        data = {data[NB_PAYLOAD-2:0], fb};
                end
                return data;
        endfunction

endpackage

`default_nettype wire

//--- design/block_source.sv
`default_nettype none
`timescale 1ns/1ps

module block_source
#(
        parameter logic [link_test_pkg::NB_PRBS-1:0] PRBS_SEED = 31'h1
)
(
        input  wire                        i_clock,
        input  wire                        i_reset,
        input  wire                        i_restart,   // reload seed at test start
        input  wire                        i_enable,    // emit one block
        output link_test_pkg::coded_block_t o_block,
        output logic                       o_valid
);

        import link_test_pkg::*;

        logic [NB_PRBS-1:0]    lfsr;
        logic [NB_PAYLOAD-1:0] next_payload;
        coded_block_t          block_q;
        logic                  valid_q;

        // all 64 bits of the next block in one step
        assign next_payload = prbs31_block(lfsr);

        // lfsr state
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        lfsr <= PRBS_SEED;
                end
                else if (i_restart)
                begin
                        lfsr <= PRBS_SEED;                   // same start point as the checker
                end
                else if (i_enable)
                begin
                        lfsr <= next_payload[NB_PRBS-1:0];    // last 31 bits out = new state
                end
        end

        // valid strobe, one cycle behind enable
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        valid_q <= 1'b0;
                end
                else
                begin
                        valid_q <= i_enable;
                end
        end

        // block register, loaded only when a block goes out
        always_ff @(posedge i_clock)
        begin
                if (i_enable)
                begin
                        block_q.sh      <= SH_DATA;          // always a data block
                        block_q.payload <= next_payload;
                end
        end

        assign o_block = block_q;
        assign o_valid = valid_q;

endmodule

`default_nettype wire

//--- design/error_injector.sv
`default_nettype none
`timescale 1ns/1ps

module error_injector
(
        input  wire                         i_clock,
        input  wire                         i_reset,
        input  wire                         i_update,   // latch config, clear counters
        input  link_test_pkg::err_cfg_t     i_cfg,
        input  link_test_pkg::coded_block_t i_block,
        input  wire                         i_valid,
        output link_test_pkg::coded_block_t o_block,
        output logic                        o_valid
);

        import link_test_pkg::*;

        err_cfg_t                 cfg_q;
        logic [NB_BURST_CNT-1:0]  burst_cnt;     // blocks corrupted in this period
        logic [NB_PERIOD_CNT-1:0] period_cnt;    // position inside the period
        logic [NB_REPEAT_CNT-1:0] repeat_cnt;    // completed periods, saturating

        logic         inj_on;
        logic         period_wrap;
        logic         corrupt;
        coded_block_t block_q;
        logic         valid_q;

        assign inj_on      = (cfg_q.error_period != '0);    // zero period turns it off
        assign period_wrap = (period_cnt == cfg_q.error_period - 1'b1);

        // flip while still inside the burst and the repeat budget
        assign corrupt = inj_on
                       && (burst_cnt < cfg_q.error_burst)
                       && (repeat_cnt < cfg_q.error_repeat);

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        cfg_q <= '0;                         // leaves injection off
                end
                else if (i_update)
                begin
                        cfg_q <= i_cfg;
                end
        end

        // counters advance per valid block, gaps do not count
        always_ff @(posedge i_clock)
        begin
                if (i_reset || i_update)
                begin
                        burst_cnt  <= '0;
                        period_cnt <= '0;
                        repeat_cnt <= '0;
                end
                else if (i_valid && inj_on)
                begin
                        if (period_wrap)
                        begin
                                period_cnt <= '0;
                                burst_cnt  <= '0;            // new burst each period
                                if (repeat_cnt < cfg_q.error_repeat)
                                begin
                                        repeat_cnt <= repeat_cnt + 1'b1;
                                end
                        end
                        else
                        begin
                                period_cnt <= period_cnt + 1'b1;
                                if (corrupt)
                                begin
                                        burst_cnt <= burst_cnt + 1'b1;
                                end
                        end
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        valid_q <= 1'b0;
                end
                else
                begin
                        valid_q <= i_valid;
                end
        end

        // output block, header untouched
        always_ff @(posedge i_clock)
        begin
                if (i_valid)
                begin
                        block_q.sh <= i_block.sh;
                        if (corrupt)
                                block_q.payload <= i_block.payload ^ cfg_q.error_mask;
                        else
                                block_q.payload <= i_block.payload;
                end
        end

        assign o_block = block_q;
        assign o_valid = valid_q;

endmodule

`default_nettype wire

//--- design/block_checker.sv
`default_nettype none
`timescale 1ns/1ps

module block_checker
#(
        parameter logic [link_test_pkg::NB_PRBS-1:0] PRBS_SEED = 31'h1
)
(
        input  wire                         i_clock,
        input  wire                         i_reset,
        input  wire                         i_restart,  // new test, clear everything
        input  link_test_pkg::coded_block_t i_block,
        input  wire                         i_valid,
        output link_test_pkg::test_report_t o_report
);

        import link_test_pkg::*;

        localparam int NB_ONES = $clog2(NB_PAYLOAD) + 1;

        logic [NB_PRBS-1:0]    lfsr;
        logic [NB_PAYLOAD-1:0] exp_payload;    // what the source should have sent
        logic [NB_PAYLOAD-1:0] diff;
        logic [NB_ONES-1:0]    diff_ones;
        logic                  sh_bad;
        test_report_t          report_q;

        assign exp_payload = prbs31_block(lfsr);
        assign diff        = i_block.payload ^ exp_payload;
        assign sh_bad      = (i_block.sh != SH_DATA);

        // popcount of the flipped bits
        always_comb
        begin
                diff_ones = '0;
                for (int i = 0; i < NB_PAYLOAD; i++)
                begin
                        diff_ones = diff_ones + NB_ONES'(diff[i]);
                end
        end

        // local reference lfsr, steps once per received block
        always_ff @(posedge i_clock)
        begin
                if (i_reset || i_restart)
                begin
                        lfsr <= PRBS_SEED;
                end
                else if (i_valid)
                begin
                        lfsr <= exp_payload[NB_PRBS-1:0];
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (i_reset || i_restart)
                begin
                        report_q <= '0;
                end
                else if (i_valid)
                begin
                        report_q.blocks_seen <= report_q.blocks_seen + 1'b1;
                        if (sh_bad)
                        begin
                                report_q.header_errors <= report_q.header_errors + 1'b1;
                        end
                        if (diff != '0)
                        begin
                                report_q.errored_blocks <= report_q.errored_blocks + 1'b1;
                                report_q.bit_errors     <= report_q.bit_errors
                                                         + NB_BIT_ERR'(diff_ones);
                        end
                end
        end

        assign o_report = report_q;

endmodule

`default_nettype wire

//--- design/link_test_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module link_test_ctrl
(
        input  wire                         i_clock,
        input  wire                         i_reset,
        input  wire                         i_start,
        input  link_test_pkg::test_cfg_t    i_cfg,
        input  link_test_pkg::test_report_t i_report,
        output logic                        o_load_cfg,
        output link_test_pkg::err_cfg_t     o_err_cfg,
        output logic                        o_gen_enable,
        output logic                        o_done,
        output link_test_pkg::test_report_t o_report
);

        import link_test_pkg::*;

        localparam logic [NB_GAP-1:0] DRAIN_LAST = NB_GAP'(2);   // 3 drain cycles

        ctrl_state_t             state;
        test_cfg_t               cfg_q;
        logic [NB_BLOCK_CNT-1:0] blk_cnt;    // strobes sent so far
        logic [NB_GAP-1:0]       gap_cnt;    // idle cycles left, reused for drain
        logic                    all_sent;
        logic                    start_ok;

        assign all_sent = (blk_cnt == cfg_q.num_blocks);
        assign start_ok = i_start && ((state == IDLE) || (state == DONE));

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        state   <= IDLE;
                        blk_cnt <= '0;
                        gap_cnt <= '0;
                end
                else
                begin
                        case (state)
                        IDLE, DONE:
                                if (start_ok)
                                        state <= LOAD;
                        LOAD:
                        begin
                                blk_cnt <= '0;
                                gap_cnt <= '0;              // first block right away
                                state   <= RUN;
                        end
                        RUN:
                                if (gap_cnt != '0)
                                        gap_cnt <= gap_cnt - 1'b1;
                                else if (all_sent)
                                begin
                                        gap_cnt <= DRAIN_LAST;
                                        state   <= DRAIN;
                                end
                                else
                                begin
                                        blk_cnt <= blk_cnt + 1'b1;   // strobe goes out now
                                        gap_cnt <= cfg_q.gap;
                                end
                        DRAIN:
                                if (gap_cnt == '0)
                                        state <= DONE;         // last block counted by now
                                else
                                        gap_cnt <= gap_cnt - 1'b1;
                        default:
                                state <= IDLE;
                        endcase
                end
        end

        // test config, taken with the start pulse
        always_ff @(posedge i_clock)
        begin
                if (start_ok)
                        cfg_q <= i_cfg;
        end

        assign o_load_cfg   = (state == LOAD);
        assign o_gen_enable = (state == RUN) && (gap_cnt == '0) && !all_sent;
        assign o_err_cfg    = cfg_q.err_cfg;
        assign o_done       = (state == DONE);
        assign o_report     = (state == DONE) ? i_report : '0;   // valid only with done

endmodule

`default_nettype wire

//--- design/link_test_top.sv
`default_nettype none
`timescale 1ns/1ps

module link_test_top
#(
        parameter logic [link_test_pkg::NB_PRBS-1:0] PRBS_SEED = 31'h2B5C_93E1
)
(
        input  wire                         i_clock,
        input  wire                         i_reset,
        input  wire                         i_start,
        input  link_test_pkg::test_cfg_t    i_cfg,
        output logic                        o_done,
        output link_test_pkg::test_report_t o_report
);

        import link_test_pkg::*;

        logic         load_cfg;       // restarts prbs and counters
        logic         gen_enable;
        err_cfg_t     err_cfg;
        coded_block_t src_block;
        logic         src_valid;
        coded_block_t inj_block;
        logic         inj_valid;
        test_report_t chk_report;

        link_test_ctrl u_ctrl (
                .i_clock      (i_clock),
                .i_reset      (i_reset),
                .i_start      (i_start),
                .i_cfg        (i_cfg),
                .i_report     (chk_report),
                .o_load_cfg   (load_cfg),
                .o_err_cfg    (err_cfg),
                .o_gen_enable (gen_enable),
                .o_done       (o_done),
                .o_report     (o_report)
        );

        block_source #(.PRBS_SEED(PRBS_SEED)) u_source (
                .i_clock   (i_clock),
                .i_reset   (i_reset),
                .i_restart (load_cfg),
                .i_enable  (gen_enable),
                .o_block   (src_block),
                .o_valid   (src_valid)
        );

        error_injector u_injector (
                .i_clock  (i_clock),
                .i_reset  (i_reset),
                .i_update (load_cfg),
                .i_cfg    (err_cfg),
                .i_block  (src_block),
                .i_valid  (src_valid),
                .o_block  (inj_block),
                .o_valid  (inj_valid)
        );

        // same seed as the source so clean blocks compare equal
        block_checker #(.PRBS_SEED(PRBS_SEED)) u_checker (
                .i_clock   (i_clock),
                .i_reset   (i_reset),
                .i_restart (load_cfg),
                .i_block   (inj_block),
                .i_valid   (inj_valid),
                .o_report  (chk_report)
        );

endmodule

`default_nettype wire

//--- test/link_test_tb.sv
`default_nettype none
`timescale 1ns/1ps

module link_test_tb;

        import link_test_pkg::*;

        localparam int DONE_TIMEOUT  = 5000;    // cycles allowed per test run
        localparam int CHECK_TIMEOUT = 10;

        logic         i_clock = 1'b0;
        logic         i_reset;
        logic         i_start;
        test_cfg_t    i_cfg;
        logic         o_done;
        test_report_t o_report;

        integer       seed = 32'h2441;
        test_report_t exp_q[$];                  // expected report per started test
        string        name_q[$];
        int           n_started = 0;
        int           n_checked = 0;
        int           n_pass = 0;
        int           n_fail = 0;
        bit           aborted = 1'b0;            // set when a wait ran out
        logic         done_q = 1'b0;

        always #2 i_clock = ~i_clock;            // 4 ns period

        link_test_top link_test_top_inst (
                .i_clock  (i_clock),
                .i_reset  (i_reset),
                .i_start  (i_start),
                .i_cfg    (i_cfg),
                .o_done   (o_done),
                .o_report (o_report)
        );

        function automatic int count_ones(input logic [NB_PAYLOAD-1:0] v);
                int ones;
                ones = 0;
                for (int i = 0; i < NB_PAYLOAD; i++)
                begin
                        if (v[i])
                                ones++;
                end
                return ones;
        endfunction

        // block k sits at k % period inside period k / period
        function automatic test_report_t expected_report(input test_cfg_t cfg);
                test_report_t rep;
                int           period;
                int           burst;
                int           repeats;
                int           errored;
                int           ones;
                rep     = '0;
                period  = int'(cfg.err_cfg.error_period);
                burst   = int'(cfg.err_cfg.error_burst);
                repeats = int'(cfg.err_cfg.error_repeat);
                ones    = count_ones(cfg.err_cfg.error_mask);
                errored = 0;
                for (int k = 0; k < int'(cfg.num_blocks); k++)
                begin
                        if (period != 0 && (k % period) < burst && (k / period) < repeats)
                                errored++;
                end
                if (ones == 0)
                        errored = 0;             // xor with nothing leaves the block clean
                rep.blocks_seen    = cfg.num_blocks;
                rep.errored_blocks = NB_BLOCK_CNT'(errored);
                rep.bit_errors     = NB_BIT_ERR'(errored * ones);
                return rep;
        endfunction

        function automatic test_cfg_t build_cfg(input logic [NB_PAYLOAD-1:0] mask,
                                                input int burst, input int period,
                                                input int repeats, input int num,
                                                input int gap);
                test_cfg_t cfg;
                cfg.err_cfg.error_mask   = mask;
                cfg.err_cfg.error_burst  = NB_BURST_CNT'(burst);
                cfg.err_cfg.error_period = NB_PERIOD_CNT'(period);
                cfg.err_cfg.error_repeat = NB_REPEAT_CNT'(repeats);
                cfg.num_blocks           = NB_BLOCK_CNT'(num);
                cfg.gap                  = NB_GAP'(gap);
                return cfg;
        endfunction

        task automatic random_cfg(output test_cfg_t cfg);
                logic [NB_PAYLOAD-1:0] mask;
                int                    burst;
                int                    period;
                int                    repeats;
                int                    num;
                int                    gap;
                mask    = {$random(seed), $random(seed)};
                burst   = $unsigned($random(seed)) % 9;
                period  = $unsigned($random(seed)) % 9;     // 0 now and then, injection off
                repeats = $unsigned($random(seed)) % 16;
                num     = 1 + $unsigned($random(seed)) % 120;
                gap     = $unsigned($random(seed)) % 8;
                cfg     = build_cfg(mask, burst, period, repeats, num, gap);
        endtask

        task automatic check_report(input string name, input test_report_t got,
                                    input test_report_t exp, output bit ok);
                ok = 1'b1;
                if (got.blocks_seen !== exp.blocks_seen)
                begin
                        $display("Fail %s o_report.blocks_seen got %h expected %h",
                                 name, got.blocks_seen, exp.blocks_seen);
                        ok = 1'b0;
                end
                if (got.errored_blocks !== exp.errored_blocks)
                begin
                        $display("Fail %s o_report.errored_blocks got %h expected %h",
                                 name, got.errored_blocks, exp.errored_blocks);
                        ok = 1'b0;
                end
                if (got.header_errors !== exp.header_errors)
                begin
                        $display("Fail %s o_report.header_errors got %h expected %h",
                                 name, got.header_errors, exp.header_errors);
                        ok = 1'b0;
                end
                if (got.bit_errors !== exp.bit_errors)
                begin
                        $display("Fail %s o_report.bit_errors got %h expected %h",
                                 name, got.bit_errors, exp.bit_errors);
                        ok = 1'b0;
                end
        endtask

        // report is read on the falling edge where done first shows up
        always @(negedge i_clock)
        begin : compare_proc
                test_report_t exp;
                string        name;
                bit           ok;
                if (o_done && !done_q)
                begin
                        if (exp_q.size() == 0)
                        begin
                                $display("done went high with no test pending");
                                n_fail++;
                        end
                        else
                        begin
                                exp  = exp_q.pop_front();
                                name = name_q.pop_front();
                                check_report(name, o_report, exp, ok);
                                if (ok)
                                begin
                                        $display("%s: ok", name);
                                        n_pass++;
                                end
                                else
                                begin
                                        $display("%s: mismatch", name);
                                        n_fail++;
                                end
                                n_checked++;
                        end
                end
                done_q = o_done;
        end

        // one start pulse, then wait for done and for its compare
        task automatic run_test(input string name, input test_cfg_t cfg);
                int cycles;
                if (!aborted)
                begin
                        exp_q.push_back(expected_report(cfg));
                        name_q.push_back(name);
                        n_started++;
                        @(negedge i_clock);
                        i_cfg   = cfg;
                        i_start = 1'b1;
                        @(negedge i_clock);
                        i_start = 1'b0;                 // fsm is in LOAD now, done is low
                        cycles  = 0;
                        while (!o_done && cycles < DONE_TIMEOUT)
                        begin
                                @(negedge i_clock);
                                cycles++;
                        end
                        if (!o_done)
                        begin
                                $display("%s never raised done within %0d cycles", name, cycles);
                                aborted = 1'b1;
                        end
                        else
                        begin
                                cycles = 0;
                                while (n_checked != n_started && cycles < CHECK_TIMEOUT)
                                begin
                                        @(negedge i_clock);
                                        cycles++;
                                end
                                if (n_checked != n_started)
                                begin
                                        $display("%s finished but its report was never compared",
                                                 name);
                                        aborted = 1'b1;
                                end
                        end
                end
        endtask

        initial
        begin : stimulus
                test_cfg_t cfg;
                int        gaps[3];
                i_reset = 1'b1;
                i_start = 1'b0;
                i_cfg   = '0;
                gaps    = '{0, 3, 15};
                repeat (4) @(negedge i_clock);
                i_reset = 1'b0;

                // nothing flipped, only blocks_seen moves
                run_test("zero_mask", build_cfg(64'h0, 4, 4, 15, 30, 0));
                run_test("zero_period", build_cfg(64'hFFFF_0000_0000_00FF, 3, 0, 5, 30, 1));

                run_test("single_bit", build_cfg(64'h0000_0010_0000_0000, 1, 4, 2, 20, 0));

                // whole periods corrupted until repeat saturates
                run_test("full_burst", build_cfg(64'h8000_0000_0000_0001, 5, 5, 3, 40, 0));

                // gaps must not shift which blocks get hit
                foreach (gaps[g])
                begin
                        cfg = build_cfg(64'h00F0_0000_0F00_0003, 2, 3, 6, 25, gaps[g]);
                        run_test($sformatf("gap_%0d", gaps[g]), cfg);
                end

                for (int i = 0; i < 6; i++)
                begin
                        random_cfg(cfg);
                        run_test($sformatf("random_%0d", i), cfg);
                end

                $display("tests %0d, passed %0d, failed %0d", n_started, n_pass,
                         n_started - n_pass);
                if (!aborted && n_fail == 0 && n_pass == n_started)
                        $display("TEST PASSED");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule

`default_nettype wire

//--- filelist.f
design/link_test_pkg.sv
design/block_source.sv
design/error_injector.sv
design/block_checker.sv
design/link_test_ctrl.sv
design/link_test_top.sv
test/link_test_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the link test simulation with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
        --top-module link_test_tb \
        --Mdir obj_dir -o link_test_sim \
        -f filelist.f

out=$(./obj_dir/link_test_sim)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"
then
        exit 0
fi
exit 1
